// File: common/frame_link_settings.svh
/* Build-time settings for the UART image link.
   FL_CLK_FREQ / FL_BAUD must be at least 4 clocks per bit. */
`ifndef FRAME_LINK_SETTINGS_SVH
`define FRAME_LINK_SETTINGS_SVH

// ==============================
// Serial link
// ==============================
`define FL_CLK_FREQ     50000000
// Simulation rate, 10 clocks per bit
`define FL_BAUD         5000000

// ==============================
// Frame and frame buffer layout
// ==============================
// Reduced frame, the board uses 640x480
`define FL_FRAME_PIXELS 64
`define FL_IMG_STRIDE   23'h04B000
`define FL_STORE_BASE   23'h100000

`endif

// File: common/frame_link_pkg.sv
/* Shared types for the UART image link.
   pix_cnt_t assumes FL_FRAME_PIXELS is at least 2. */
`include "frame_link_settings.svh"

package frame_link_pkg;

  // ==============================
  // Data widths
  // ==============================
  typedef logic [11:0] pixel_t;
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  img_idx_t;
  // Frame-buffer word address
  typedef logic [22:0] addr_t;
  // Store address and pixel counter
  typedef logic [$clog2(`FL_FRAME_PIXELS)-1:0] pix_cnt_t;

  // ==============================
  // State machines
  // ==============================
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_FETCH,
    TX_SEND,
    TX_WAIT
  } tx_state_t;

endpackage

// File: uart/uart_rx.sv
/* 8N1 receiver, LSB first. Frames with a low stop bit are dropped
   and give no valid pulse. */
`timescale 1ns/1ns
`include "frame_link_settings.svh"

module uart_rx (
  input  logic                  CLOCK_50,
  input  logic                  DLY_RST_0,
  input  logic                  rx,
  output frame_link_pkg::byte_t rx_byte,
  output logic                  rx_valid
);

  localparam int BIT_CLKS = `FL_CLK_FREQ / `FL_BAUD;
  localparam int CNT_W = $clog2(BIT_CLKS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(BIT_CLKS - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BIT_CLKS / 2 - 1);

  logic                      rx_meta;
  logic                      rx_sync;
  logic                      rx_prev;
  logic                      start_edge;
  logic                      bit_end;
  logic [CNT_W-1:0]          baud_cnt;
  logic [2:0]                bit_idx;
  frame_link_pkg::rx_state_t state;
  frame_link_pkg::byte_t     shift_reg;

  // Two-flop synchronizer plus one stage for edge detection
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev & ~rx_sync;
  assign bit_end    = (baud_cnt == BIT_LAST);

  // ==============================
  // Receive FSM
  // ==============================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state    <= frame_link_pkg::RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        frame_link_pkg::RX_IDLE: begin
          baud_cnt <= '0;
          if (start_edge) begin
            state <= frame_link_pkg::RX_START;
          end
        end
        frame_link_pkg::RX_START: begin
          // Middle of the start bit, a high line here was a glitch
          if (baud_cnt == HALF_LAST) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_sync ? frame_link_pkg::RX_IDLE : frame_link_pkg::RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        frame_link_pkg::RX_DATA: begin
          if (bit_end) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= frame_link_pkg::RX_STOP;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        frame_link_pkg::RX_STOP: begin
          if (bit_end) begin
            state    <= frame_link_pkg::RX_IDLE;
            rx_valid <= rx_sync;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= frame_link_pkg::RX_IDLE;
      endcase
    end
  end

  // Data path, sampled at mid-bit
  always_ff @(posedge CLOCK_50) begin
    if (state == frame_link_pkg::RX_DATA && bit_end) begin
      shift_reg <= {rx_sync, shift_reg[7:1]};
    end
    if (state == frame_link_pkg::RX_STOP && bit_end && rx_sync) begin
      rx_byte <= shift_reg;
    end
  end

endmodule

// File: uart/uart_tx.sv
/* 8N1 transmitter, LSB first. A strobe while a byte is still
   on the line is ignored. */
`timescale 1ns/1ns
`include "frame_link_settings.svh"

module uart_tx (
  input  logic                  CLOCK_50,
  input  logic                  DLY_RST_0,
  input  logic                  tx_strobe,
  input  frame_link_pkg::byte_t tx_byte,
  output logic                  tx,
  output logic                  tx_done
);

  localparam int BIT_CLKS = `FL_CLK_FREQ / `FL_BAUD;
  localparam int CNT_W = $clog2(BIT_CLKS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(BIT_CLKS - 1);

  logic [9:0]       shift_reg;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic             active;

  // Bit 0 of the shift register drives the line
  assign tx = shift_reg[0];

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      shift_reg <= '1;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      active    <= 1'b0;
      tx_done   <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (!active) begin
        if (tx_strobe) begin
          // Stop, data, start
          shift_reg <= {1'b1, tx_byte, 1'b0};
          baud_cnt  <= '0;
          bit_cnt   <= '0;
          active    <= 1'b1;
        end
      end else if (baud_cnt == BIT_LAST) begin
        baud_cnt  <= '0;
        shift_reg <= {1'b1, shift_reg[9:1]};
        bit_cnt   <= bit_cnt + 1'b1;
        // End of the stop bit
        if (bit_cnt == 4'd9) begin
          active  <= 1'b0;
          tx_done <= 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

// File: src/image_select.sv
/* Image index from the serial link and frame-buffer read base.
   Back-to-back changes of the selection merge into one long reset. */
`timescale 1ns/1ns
`include "frame_link_settings.svh"

module image_select (
  input  logic                     CLOCK_50,
  input  logic                     DLY_RST_0,
  input  frame_link_pkg::byte_t    rx_byte,
  input  logic                     rx_valid,
  input  logic                     sel_lock,
  input  logic                     live_mode,
  output frame_link_pkg::img_idx_t cur_img,
  output frame_link_pkg::addr_t    read_base,
  output logic                     disp_rst_n
);

  frame_link_pkg::img_idx_t prev_img;
  logic                     prev_live;
  logic                     sel_changed;

  // Selection register, frozen while locked
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      cur_img <= '0;
    end else if (rx_valid && !sel_lock) begin
      cur_img <= frame_link_pkg::img_idx_t'(rx_byte);
    end
  end

  // Live view reads from address 0, stored images from the base region
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      read_base <= `FL_STORE_BASE;
    end else if (live_mode) begin
      read_base <= '0;
    end else begin
      read_base <= frame_link_pkg::addr_t'(`FL_STORE_BASE)
                 + frame_link_pkg::addr_t'(`FL_IMG_STRIDE)
                 * frame_link_pkg::addr_t'(cur_img);
    end
  end

  // ==============================
  // Display reset on change
  // ==============================
  assign sel_changed = ({cur_img, live_mode} != {prev_img, prev_live});

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      prev_img   <= '0;
      prev_live  <= 1'b0;
      disp_rst_n <= 1'b1;
    end else begin
      prev_img   <= cur_img;
      prev_live  <= live_mode;
      disp_rst_n <= ~sel_changed;
    end
  end

endmodule

// File: src/frame_store.sv
/* One greyscale frame of FL_FRAME_PIXELS pixels, registered read.
   Pixels past the frame size wrap onto address 0. */
`timescale 1ns/1ns
`include "frame_link_settings.svh"

module frame_store (
  input  logic                     CLOCK_50,
  input  logic                     DLY_RST_0,
  input  frame_link_pkg::pixel_t   pix_data,
  input  logic                     pix_valid,
  input  logic                     frame_start,
  input  frame_link_pkg::pix_cnt_t rd_addr,
  output frame_link_pkg::pixel_t   rd_data
);

  localparam frame_link_pkg::pix_cnt_t LAST_PIX =
    frame_link_pkg::pix_cnt_t'(`FL_FRAME_PIXELS - 1);

  frame_link_pkg::pixel_t   mem [`FL_FRAME_PIXELS];
  frame_link_pkg::pix_cnt_t wr_ptr;
  frame_link_pkg::pix_cnt_t wr_addr;

  // A pixel arriving with frame_start lands at address 0
  assign wr_addr = frame_start ? '0 : wr_ptr;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      wr_ptr <= '0;
    end else if (pix_valid) begin
      wr_ptr <= (wr_addr == LAST_PIX) ? '0 : wr_addr + 1'b1;
    end else if (frame_start) begin
      wr_ptr <= '0;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (pix_valid) begin
      mem[wr_addr] <= pix_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

// File: src/frame_sender.sv
/* Streams the stored frame, one byte per pixel from bits 11:4.
   After an abort the next strobe waits for the byte on the line. */
`timescale 1ns/1ns
`include "frame_link_settings.svh"

module frame_sender (
  input  logic                     CLOCK_50,
  input  logic                     DLY_RST_0,
  input  logic                     send_start,
  input  logic                     send_abort,
  input  frame_link_pkg::pixel_t   rd_data,
  input  logic                     tx_done,
  output frame_link_pkg::pix_cnt_t rd_addr,
  output logic                     tx_strobe,
  output frame_link_pkg::byte_t    tx_byte,
  output logic                     tx_busy
);

  localparam frame_link_pkg::pix_cnt_t LAST_PIX =
    frame_link_pkg::pix_cnt_t'(`FL_FRAME_PIXELS - 1);

  frame_link_pkg::tx_state_t state;
  // Byte handed to the transmitter and not yet done
  logic                      line_busy;

  assign tx_strobe = (state == frame_link_pkg::TX_SEND) && !line_busy;
  assign tx_byte   = frame_link_pkg::byte_t'(rd_data[11:4]);
  assign tx_busy   = (state != frame_link_pkg::TX_IDLE);

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      line_busy <= 1'b0;
    end else if (tx_strobe) begin
      line_busy <= 1'b1;
    end else if (tx_done) begin
      line_busy <= 1'b0;
    end
  end

  // ==============================
  // Send FSM
  // ==============================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state   <= frame_link_pkg::TX_IDLE;
      rd_addr <= '0;
    end else if (send_abort && tx_busy) begin
      state <= frame_link_pkg::TX_IDLE;
    end else begin
      case (state)
        frame_link_pkg::TX_IDLE: begin
          if (send_start) begin
            rd_addr <= '0;
            state   <= frame_link_pkg::TX_FETCH;
          end
        end
        // Store read takes this cycle
        frame_link_pkg::TX_FETCH: state <= frame_link_pkg::TX_SEND;
        frame_link_pkg::TX_SEND: begin
          if (!line_busy) begin
            state <= frame_link_pkg::TX_WAIT;
          end
        end
        frame_link_pkg::TX_WAIT: begin
          if (tx_done) begin
            if (rd_addr == LAST_PIX) begin
              state <= frame_link_pkg::TX_IDLE;
            end else begin
              rd_addr <= rd_addr + 1'b1;
              state   <= frame_link_pkg::TX_FETCH;
            end
          end
        end
        default: state <= frame_link_pkg::TX_IDLE;
      endcase
    end
  end

endmodule

// File: src/frame_link_top.sv
/* UART image link: selector, one-frame store and frame sender.
   Camera pixels must already be synchronous to CLOCK_50. */
`timescale 1ns/1ns

module frame_link_top (
  input  logic                     CLOCK_50,
  input  logic                     DLY_RST_0,
  input  logic                     rx,
  output logic                     tx,
  input  frame_link_pkg::pixel_t   pix_data,
  input  logic                     pix_valid,
  input  logic                     frame_start,
  input  logic                     send_start,
  input  logic                     send_abort,
  input  logic                     sel_lock,
  input  logic                     live_mode,
  output frame_link_pkg::img_idx_t cur_img,
  output frame_link_pkg::addr_t    read_base,
  output logic                     disp_rst_n,
  output logic                     tx_busy
);

  frame_link_pkg::byte_t    rx_byte;
  logic                     rx_valid;
  frame_link_pkg::pix_cnt_t rd_addr;
  frame_link_pkg::pixel_t   rd_data;
  logic                     tx_strobe;
  frame_link_pkg::byte_t    tx_byte;
  logic                     tx_done;

  // ==============================
  // Image selection path
  // ==============================
  uart_rx i_uart_rx (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  image_select i_image_select (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .sel_lock  (sel_lock),
    .live_mode (live_mode),
    .cur_img   (cur_img),
    .read_base (read_base),
    .disp_rst_n(disp_rst_n)
  );

  // ==============================
  // Capture and frame send path
  // ==============================
  frame_store i_frame_store (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .pix_data   (pix_data),
    .pix_valid  (pix_valid),
    .frame_start(frame_start),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  frame_sender i_frame_sender (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .send_start(send_start),
    .send_abort(send_abort),
    .rd_data   (rd_data),
    .tx_done   (tx_done),
    .rd_addr   (rd_addr),
    .tx_strobe (tx_strobe),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy)
  );

  uart_tx i_uart_tx (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .tx_strobe(tx_strobe),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

endmodule

// File: bench/frame_link_props.sv
/* Handshake and reset checks for frame_link_top, attached by bind.
   Reset values are checked on the first clock after release. */
`timescale 1ns/1ns
`include "frame_link_settings.svh"

module frame_link_props (
  input logic                     CLOCK_50,
  input logic                     DLY_RST_0,
  input logic                     tx_strobe,
  input logic                     tx,
  input logic                     tx_busy,
  input logic                     rx_valid,
  input logic                     disp_rst_n,
  input frame_link_pkg::img_idx_t cur_img,
  input frame_link_pkg::addr_t    read_base
);

  localparam int BYTE_CLKS = 10 * (`FL_CLK_FREQ / `FL_BAUD);

  // Clocks left of the byte on the line, ten bit times from its strobe
  int          line_left;
  int unsigned fail_cnt = 0;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      line_left <= 0;
    end else if (tx_strobe) begin
      line_left <= BYTE_CLKS;
    end else if (line_left != 0) begin
      line_left <= line_left - 1;
    end
  end

  // ==============================
  // Handshakes
  // ==============================
  strobe_on_idle_line: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) tx_strobe |-> (line_left == 0)
  ) else begin
    fail_cnt++;
    $error("tx_strobe while a byte is still on the line");
  end

  disp_rst_single_cycle: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) !disp_rst_n |=> disp_rst_n
  ) else begin
    fail_cnt++;
    $error("disp_rst_n low for two cycles in a row");
  end

  // ==============================
  // Values right after reset
  // ==============================
  reset_values: assert property (
    @(posedge CLOCK_50) $rose(DLY_RST_0) |->
      (!tx_busy && !tx_strobe && tx && !rx_valid && disp_rst_n &&
       cur_img == '0 && read_base == `FL_STORE_BASE)
  ) else begin
    fail_cnt++;
    $error("Outputs differ from their reset values after reset release");
  end

endmodule

// File: bench/frame_link_tb.sv
/* Directed tests for the UART image link. Serial timing follows
   FL_CLK_FREQ / FL_BAUD, random data comes from a fixed seed. */
`timescale 1ns/1ns
`include "frame_link_settings.svh"

module frame_link_tb;

  localparam int BIT_CLKS = `FL_CLK_FREQ / `FL_BAUD;
  localparam int NPIX = `FL_FRAME_PIXELS;
  // Longest expected gap before a DUT response, with margin
  localparam int WAIT_CLKS = 4 * BIT_CLKS + 16;

  logic                     CLOCK_50;
  logic                     DLY_RST_0;
  logic                     rx;
  logic                     tx;
  frame_link_pkg::pixel_t   pix_data;
  logic                     pix_valid;
  logic                     frame_start;
  logic                     send_start;
  logic                     send_abort;
  logic                     sel_lock;
  logic                     live_mode;
  frame_link_pkg::img_idx_t cur_img;
  frame_link_pkg::addr_t    read_base;
  logic                     disp_rst_n;
  logic                     tx_busy;

  frame_link_pkg::pixel_t   pix_mem [NPIX];
  int                       disp_pulses = 0;

  frame_link_top i_frame_link_top (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .rx         (rx),
    .tx         (tx),
    .pix_data   (pix_data),
    .pix_valid  (pix_valid),
    .frame_start(frame_start),
    .send_start (send_start),
    .send_abort (send_abort),
    .sel_lock   (sel_lock),
    .live_mode  (live_mode),
    .cur_img    (cur_img),
    .read_base  (read_base),
    .disp_rst_n (disp_rst_n),
    .tx_busy    (tx_busy)
  );

  bind frame_link_top frame_link_props i_frame_link_props (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .tx_strobe (tx_strobe),
    .tx        (tx),
    .tx_busy   (tx_busy),
    .rx_valid  (rx_valid),
    .disp_rst_n(disp_rst_n),
    .cur_img   (cur_img),
    .read_base (read_base)
  );

  always #5 CLOCK_50 = ~CLOCK_50;

  // Display reset low cycles, counted at the falling edge
  always @(negedge CLOCK_50) begin
    if (DLY_RST_0 && !disp_rst_n) begin
      disp_pulses <= disp_pulses + 1;
    end
  end

  // ==============================
  // Helpers
  // ==============================
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endtask

  // Stored image address, one stride per index step
  function automatic frame_link_pkg::addr_t base_for(input frame_link_pkg::img_idx_t img);
    frame_link_pkg::addr_t addr;
    addr = `FL_STORE_BASE;
    for (int i = 0; i < int'(img); i++) begin
      addr = addr + `FL_IMG_STRIDE;
    end
    return addr;
  endfunction

  function automatic frame_link_pkg::img_idx_t new_img(input frame_link_pkg::img_idx_t old);
    frame_link_pkg::img_idx_t img;
    img = frame_link_pkg::img_idx_t'($urandom);
    if (img == old) begin
      img = img + 8'd1;
    end
    return img;
  endfunction

  // Ends with one idle bit time, which covers the receiver latency
  task automatic send_rx_byte(input frame_link_pkg::byte_t b, input logic stop_bit);
    @(negedge CLOCK_50);
    rx = 1'b0;
    repeat (BIT_CLKS) @(negedge CLOCK_50);
    for (int i = 0; i < 8; i++) begin
      rx = b[i];
      repeat (BIT_CLKS) @(negedge CLOCK_50);
    end
    rx = stop_bit;
    repeat (BIT_CLKS) @(negedge CLOCK_50);
    rx = 1'b1;
    repeat (BIT_CLKS) @(negedge CLOCK_50);
  endtask

  task automatic wait_cur_img(input frame_link_pkg::img_idx_t expected);
    int t;
    t = 0;
    while (cur_img != expected && t < WAIT_CLKS) begin
      @(negedge CLOCK_50);
      t++;
    end
    assert (cur_img == expected)
      else fail_run($sformatf("[ERROR] cur_img: got %h, expected %h", cur_img, expected));
  endtask

  task automatic wait_disp_pulses(input int expected);
    int t;
    t = 0;
    while (disp_pulses < expected && t < WAIT_CLKS) begin
      @(negedge CLOCK_50);
      t++;
    end
    repeat (4) @(negedge CLOCK_50);
    assert (disp_pulses == expected)
      else fail_run($sformatf("[ERROR] disp_rst_n low cycles: got %h, expected %h",
                              disp_pulses, expected));
  endtask

  task automatic wait_tx_start();
    int t;
    t = 0;
    while (tx != 1'b0 && t < WAIT_CLKS) begin
      @(negedge CLOCK_50);
      t++;
    end
    assert (tx == 1'b0) else fail_run("No start bit appeared on tx in time");
  endtask

  // Decodes one byte at mid-bit, optionally aborting just after its start bit
  task automatic read_tx_byte(input logic abort_mid, output frame_link_pkg::byte_t b);
    wait_tx_start();
    if (abort_mid) begin
      send_abort = 1'b1;
      @(negedge CLOCK_50);
      send_abort = 1'b0;
      assert (!tx_busy)
        else fail_run($sformatf("[ERROR] tx_busy: got %h, expected 0 after abort", tx_busy));
      repeat (BIT_CLKS / 2 - 1) @(negedge CLOCK_50);
    end else begin
      repeat (BIT_CLKS / 2) @(negedge CLOCK_50);
    end
    assert (tx == 1'b0) else fail_run("Start bit on tx ended before mid-bit");
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge CLOCK_50);
      b[i] = tx;
    end
    repeat (BIT_CLKS) @(negedge CLOCK_50);
    assert (tx == 1'b1) else fail_run("Stop bit on tx was low");
  endtask

  task automatic check_frame_bytes(input int first, input int n);
    frame_link_pkg::byte_t b;
    for (int i = first; i < first + n; i++) begin
      read_tx_byte(1'b0, b);
      assert (b == pix_mem[i][11:4])
        else fail_run($sformatf("[ERROR] tx byte %0d: got %h, expected %h",
                                i, b, pix_mem[i][11:4]));
    end
  endtask

  task automatic wait_busy_low();
    int t;
    t = 0;
    while (tx_busy && t < WAIT_CLKS) begin
      @(negedge CLOCK_50);
      t++;
    end
    assert (!tx_busy) else fail_run("tx_busy did not fall after the last byte");
  endtask

  // No further byte may start once the sender is idle
  task automatic check_line_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge CLOCK_50);
      assert (tx == 1'b1 && !tx_busy)
        else fail_run("tx line became active while the sender was idle");
    end
  endtask

  task automatic pulse_send_start();
    @(negedge CLOCK_50);
    send_start = 1'b1;
    @(negedge CLOCK_50);
    send_start = 1'b0;
    assert (tx_busy)
      else fail_run($sformatf("[ERROR] tx_busy: got %h, expected 1 after start", tx_busy));
  endtask

  // A few stray pixels first, so frame_start must rewind the store
  task automatic load_frame();
    @(negedge CLOCK_50);
    pix_valid = 1'b1;
    for (int i = 0; i < 3; i++) begin
      pix_data = frame_link_pkg::pixel_t'($urandom);
      @(negedge CLOCK_50);
    end
    for (int i = 0; i < NPIX; i++) begin
      pix_mem[i]  = frame_link_pkg::pixel_t'($urandom);
      pix_data    = pix_mem[i];
      frame_start = (i == 0);
      @(negedge CLOCK_50);
    end
    pix_valid   = 1'b0;
    frame_start = 1'b0;
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_reset_state();
    assert (cur_img == '0)
      else fail_run($sformatf("[ERROR] cur_img: got %h, expected 00", cur_img));
    assert (read_base == `FL_STORE_BASE)
      else fail_run($sformatf("[ERROR] read_base: got %h, expected %h",
                              read_base, `FL_STORE_BASE));
    assert (tx == 1'b1) else fail_run($sformatf("[ERROR] tx: got %h, expected 1", tx));
    assert (!tx_busy) else fail_run($sformatf("[ERROR] tx_busy: got %h, expected 0", tx_busy));
    assert (disp_rst_n)
      else fail_run($sformatf("[ERROR] disp_rst_n: got %h, expected 1", disp_rst_n));
  endtask

  task automatic test_image_select();
    frame_link_pkg::img_idx_t img;
    frame_link_pkg::img_idx_t locked_img;
    img = new_img(cur_img);
    send_rx_byte(img, 1'b1);
    wait_cur_img(img);
    @(negedge CLOCK_50);
    assert (read_base == base_for(img))
      else fail_run($sformatf("[ERROR] read_base: got %h, expected %h", read_base, base_for(img)));
    sel_lock   = 1'b1;
    locked_img = new_img(img);
    send_rx_byte(locked_img, 1'b1);
    assert (cur_img == img)
      else fail_run($sformatf("[ERROR] cur_img: got %h, expected %h while locked", cur_img, img));
    sel_lock = 1'b0;
  endtask

  task automatic test_display_reset();
    frame_link_pkg::img_idx_t img;
    int                       base;
    base = disp_pulses;
    img  = new_img(cur_img);
    send_rx_byte(img, 1'b1);
    wait_cur_img(img);
    wait_disp_pulses(base + 1);
    live_mode = 1'b1;
    wait_disp_pulses(base + 2);
    assert (read_base == '0)
      else fail_run($sformatf("[ERROR] read_base: got %h, expected 0 in live mode", read_base));
    live_mode = 1'b0;
    wait_disp_pulses(base + 3);
    assert (read_base == base_for(img))
      else fail_run($sformatf("[ERROR] read_base: got %h, expected %h", read_base, base_for(img)));
  endtask

  task automatic test_frame_send();
    load_frame();
    pulse_send_start();
    check_frame_bytes(0, NPIX);
    wait_busy_low();
    check_line_idle(3 * BIT_CLKS);
  endtask

  task automatic test_abort_restart();
    frame_link_pkg::byte_t b;
    pulse_send_start();
    check_frame_bytes(0, 5);
    // Byte 5 is already on the line when the abort arrives
    read_tx_byte(1'b1, b);
    assert (b == pix_mem[5][11:4])
      else fail_run($sformatf("[ERROR] tx byte 5: got %h, expected %h", b, pix_mem[5][11:4]));
    check_line_idle(3 * BIT_CLKS);
    pulse_send_start();
    check_frame_bytes(0, NPIX);
    wait_busy_low();
    check_line_idle(3 * BIT_CLKS);
  endtask

  task automatic test_bad_stop();
    frame_link_pkg::img_idx_t old_img;
    frame_link_pkg::img_idx_t img;
    int                       base;
    old_img = cur_img;
    base    = disp_pulses;
    img     = new_img(old_img);
    send_rx_byte(img, 1'b0);
    assert (cur_img == old_img)
      else fail_run($sformatf("[ERROR] cur_img: got %h, expected %h after bad stop bit",
                              cur_img, old_img));
    assert (disp_pulses == base)
      else fail_run($sformatf("[ERROR] disp_rst_n low cycles: got %h, expected %h",
                              disp_pulses, base));
    // Receiver must still take the next good byte
    send_rx_byte(img, 1'b1);
    wait_cur_img(img);
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    CLOCK_50    = 1'b0;
    DLY_RST_0   = 1'b0;
    rx          = 1'b1;
    pix_data    = '0;
    pix_valid   = 1'b0;
    frame_start = 1'b0;
    send_start  = 1'b0;
    send_abort  = 1'b0;
    sel_lock    = 1'b0;
    live_mode   = 1'b0;
    void'($urandom(32'he52d_7981));
    repeat (4) @(negedge CLOCK_50);
    DLY_RST_0 = 1'b1;
    @(negedge CLOCK_50);

    test_reset_state();
    test_image_select();
    test_display_reset();
    test_frame_send();
    test_abort_restart();
    test_bad_stop();

    if (i_frame_link_top.i_frame_link_props.fail_cnt != 0) begin
      fail_run("A bound assertion failed during the run");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: frame_link_top.f
+incdir+common
common/frame_link_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
src/image_select.sv
src/frame_store.sv
src/frame_sender.sv
src/frame_link_top.sv
bench/frame_link_props.sv
bench/frame_link_tb.sv

// File: run.sh
#!/bin/sh
# Builds the UART image link testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
  --top-module frame_link_tb \
  -f frame_link_top.f \
  -o frame_link_sim

./obj_dir/frame_link_sim
